/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir
	out=$$(./obj_dir/Vtb_top +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* dv/exu_assert.sv */
`timescale 1ns/1ps

module exu_assert
    import pipe_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         id_valid,
    input logic         ex_ready,
    input logic         ls_valid,
    input logic         ls_ready,
    input logic         ls_flush,
    input exec_bundle_t ls_bundle
);

    int fail_count = 0;

    // held entry keeps its payload until memory takes it
    hold_under_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        ls_valid && !ls_ready && !ls_flush |=> ls_valid && $stable(ls_bundle))
    else begin
        $error("ls_bundle or ls_valid changed while ls_ready was low");
        fail_count++;
    end

    flush_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ls_flush |=> !ls_valid)
    else begin
        $error("ls_valid still high after ls_flush");
        fail_count++;
    end

    flush_blocks_accept: assert property (@(posedge clk) disable iff (!rst_n)
        ls_flush |-> !ex_ready)
    else begin
        $error("ex_ready high during ls_flush");
        fail_count++;
    end

    ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ex_ready |-> id_valid)
    else begin
        $error("ex_ready high without id_valid");
        fail_count++;
    end

endmodule

bind exu_top exu_assert i_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .id_valid  (id_valid),
    .ex_ready  (ex_ready),
    .ls_valid  (ls_valid),
    .ls_ready  (ls_ready),
    .ls_flush  (ls_flush),
    .ls_bundle (ls_bundle)
);

/* dv/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           id_valid,
    input  decode_bundle_t id_bundle,
    input  logic           ex_ready,
    input  logic           ex_flush,
    input  logic           ls_valid,
    input  exec_bundle_t   ls_bundle,
    input  logic           ls_ready,
    input  logic           ls_flush,
    input  redirect_t      redirect,
    input  logic           report_done,
    output int             total_checks,
    output int             total_errors
);

    exec_bundle_t expected_q[$];
    logic         exp_valid;
    logic         jump_done;
    int           checks[5];
    int           fails[5];
    string        test_name[5];

    initial begin
        test_name[0] = "alu_result";
        test_name[1] = "next_pc_and_fields";
        test_name[2] = "ordering";
        test_name[3] = "redirect";
        test_name[4] = "handshake_and_flush";
        total_checks = 0;
        total_errors = 0;
    end

    task automatic report_error(input int grp, input string msg);
        $display("error %0t: %s", $time, msg);
        fails[grp]++;
    endtask

    // ********************************************************
    // reference model
    // ********************************************************
    // signed compare by flipping the sign bits
    function automatic logic signed_less(input logic [xlen-1:0] a, input logic [xlen-1:0] c);
        logic [xlen-1:0] msb;
        msb = {1'b1, {(xlen - 1){1'b0}}};
        return (a ^ msb) < (c ^ msb);
    endfunction

    function automatic logic [xlen-1:0] model_alu(input decode_bundle_t b);
        logic [xlen-1:0]   a;
        logic [xlen-1:0]   c;
        logic [31:0]       w;
        logic [2*xlen-1:0] ext;
        a = b.operand1;
        c = b.operand2;
        if (b.word && b.alu_op inside {alu_add, alu_sub, alu_sll, alu_srl, alu_sra}) begin
            case (b.alu_op)
                alu_add: w = a[31:0] + c[31:0];
                alu_sub: w = a[31:0] - c[31:0];
                alu_sll: w = a[31:0] << c[4:0];
                alu_srl: w = a[31:0] >> c[4:0];
                default: begin
                    // sraw as a logical shift of the sign-filled word
                    ext = {{96{a[31]}}, a[31:0]} >> c[4:0];
                    w   = ext[31:0];
                end
            endcase
            return {{32{w[31]}}, w};
        end
        case (b.alu_op)
            alu_add:  return a + c;
            alu_sub:  return a - c;
            alu_and:  return a & c;
            alu_or:   return a | c;
            alu_xor:  return a ^ c;
            alu_sll:  return a << c[5:0];
            alu_srl:  return a >> c[5:0];
            alu_sra: begin
                ext = {{xlen{a[63]}}, a} >> c[5:0];
                return ext[xlen-1:0];
            end
            alu_slt:  return {{(xlen - 1){1'b0}}, signed_less(a, c)};
            alu_sltu: return {{(xlen - 1){1'b0}}, a < c};
            default:  return '0;
        endcase
    endfunction

    function automatic logic model_taken(input decode_bundle_t b);
        logic cond;
        case (b.br_op)
            br_eq:   cond = (b.operand1 == b.operand2);
            br_ne:   cond = (b.operand1 != b.operand2);
            br_lt:   cond = signed_less(b.operand1, b.operand2);
            br_ge:   cond = !signed_less(b.operand1, b.operand2);
            br_ltu:  cond = (b.operand1 < b.operand2);
            br_geu:  cond = !(b.operand1 < b.operand2);
            default: cond = 1'b0;
        endcase
        return b.jump_valid || (b.br_valid && cond);
    endfunction

    function automatic logic [xlen-1:0] model_target(input decode_bundle_t b);
        logic [xlen-1:0] sum;
        sum    = b.target_a + b.target_b;
        sum[0] = 1'b0;
        return sum;
    endfunction

    function automatic exec_bundle_t expected_bundle(input decode_bundle_t b, input logic taken,
                                                     input logic [xlen-1:0] target);
        exec_bundle_t e;
        e.pc         = b.pc;
        e.next_pc    = taken ? target : b.next_pc;
        e.inst       = b.inst;
        e.rd         = b.rd;
        e.dest_wen   = b.dest_wen;
        e.mem_ctrl   = b.mem_ctrl;
        e.store_data = b.store_data;
        e.result     = model_alu(b);
        return e;
    endfunction

    // ********************************************************
    // comparison, once per cycle at the falling edge
    // ********************************************************
    task automatic compare_out(input exec_bundle_t exp);
        checks[0]++;
        if (ls_bundle.result !== exp.result) begin
            report_error(0, $sformatf("result %h, expected %h (pc %h)",
                                      ls_bundle.result, exp.result, exp.pc));
        end
        checks[1]++;
        if (ls_bundle.next_pc !== exp.next_pc) begin
            report_error(1, $sformatf("next_pc %h, expected %h", ls_bundle.next_pc, exp.next_pc));
        end else if (ls_bundle.pc !== exp.pc || ls_bundle.inst !== exp.inst ||
                     ls_bundle.rd !== exp.rd || ls_bundle.dest_wen !== exp.dest_wen ||
                     ls_bundle.mem_ctrl !== exp.mem_ctrl ||
                     ls_bundle.store_data !== exp.store_data) begin
            report_error(1, $sformatf("carried fields differ for pc %h", exp.pc));
        end
    endtask

    task automatic check_cycle();
        logic            exp_ready;
        logic            accept;
        logic            taken;
        logic            exp_redir;
        logic [xlen-1:0] target;
        exp_ready = id_valid && (!exp_valid || ls_ready) && !ls_flush;
        accept    = id_valid && exp_ready;
        taken     = id_valid && model_taken(id_bundle);
        target    = model_target(id_bundle);
        exp_redir = taken && !jump_done;

        checks[4]++;
        if (ex_ready !== exp_ready) begin
            report_error(4, $sformatf("ex_ready %b, expected %b", ex_ready, exp_ready));
        end
        checks[3]++;
        if (redirect.valid !== exp_redir || ex_flush !== (ls_flush || exp_redir)) begin
            report_error(3, $sformatf("redirect.valid %b ex_flush %b, expected %b %b",
                                      redirect.valid, ex_flush, exp_redir, ls_flush || exp_redir));
        end else if (exp_redir && redirect.addr !== target) begin
            report_error(3, $sformatf("redirect.addr %h, expected %h", redirect.addr, target));
        end
        checks[2]++;
        if (ls_valid !== exp_valid) begin
            report_error(2, $sformatf("ls_valid %b, expected %b", ls_valid, exp_valid));
        end

        // head of the queue is the entry in the output register
        if (exp_valid) begin
            compare_out(expected_q[0]);
            if (ls_ready || ls_flush) begin
                void'(expected_q.pop_front());
            end
        end
        if (accept) begin
            expected_q.push_back(expected_bundle(id_bundle, taken, target));
        end

        if (ls_flush) begin
            exp_valid = 1'b0;
        end else if (!exp_valid || ls_ready) begin
            exp_valid = accept;
        end
        if (ls_flush || accept) begin
            jump_done = 1'b0;
        end else if (taken) begin
            jump_done = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            exp_valid = 1'b0;
            jump_done = 1'b0;
        end else begin
            check_cycle();
        end
    end

    // ********************************************************
    // summary
    // ********************************************************
    always @(posedge report_done) begin
        if (expected_q.size() != 0) begin
            report_error(2, $sformatf("%0d accepted instructions never left the stage",
                                      expected_q.size()));
        end
        for (int i = 0; i < 5; i++) begin
            $display("test %s: %0d checks, %0d errors", test_name[i], checks[i], fails[i]);
            total_checks += checks[i];
            total_errors += fails[i];
        end
    end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for 8 cycles, released away from the edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int num_insts  = 2000;
    localparam int max_cycles = 40 * num_insts;

    logic           clk;
    logic           rst_n;
    logic           id_valid;
    decode_bundle_t id_bundle;
    logic           ex_ready;
    logic           ex_flush;
    logic           ls_valid;
    exec_bundle_t   ls_bundle;
    logic           ls_ready;
    logic           ls_flush;
    redirect_t      redirect;
    logic           report_done;
    int             chk_checks;
    int             chk_errors;
    int             assert_fails;
    int             seed;
    int             cycles = 0;
    int             n_sent;
    logic           accepted;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_valid  (id_valid),
        .id_bundle (id_bundle),
        .ex_ready  (ex_ready),
        .ex_flush  (ex_flush),
        .ls_valid  (ls_valid),
        .ls_bundle (ls_bundle),
        .ls_ready  (ls_ready),
        .ls_flush  (ls_flush),
        .redirect  (redirect)
    );

    tb_checker i_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_valid     (id_valid),
        .id_bundle    (id_bundle),
        .ex_ready     (ex_ready),
        .ex_flush     (ex_flush),
        .ls_valid     (ls_valid),
        .ls_bundle    (ls_bundle),
        .ls_ready     (ls_ready),
        .ls_flush     (ls_flush),
        .redirect     (redirect),
        .report_done  (report_done),
        .total_checks (chk_checks),
        .total_errors (chk_errors)
    );

    // ********************************************************
    // random stimulus
    // ********************************************************
    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [xlen-1:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // zero, all ones and the most negative value show up often
    function automatic logic [xlen-1:0] edge_operand();
        case (pick(8))
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(xlen - 1){1'b0}}};
            default: return rand64();
        endcase
    endfunction

    task automatic make_bundle(output decode_bundle_t b);
        int unsigned kind;
        b            = '0;
        b.pc         = rand64() & ~64'h3;
        b.next_pc    = b.pc + 64'd4;
        b.inst       = $random(seed);
        b.rd         = 5'(pick(32));
        b.dest_wen   = 1'(pick(2));
        b.alu_op     = alu_op_e'(4'(pick(10)));
        b.word       = 1'(pick(2));
        b.br_op      = br_op_e'(3'(pick(6)));
        kind         = pick(4);
        b.jump_valid = (kind == 0);
        b.br_valid   = (kind == 1);
        b.mem_ctrl   = mem_ctrl_t'(5'(pick(32)));
        b.store_data = rand64();
        b.operand1   = edge_operand();
        // equal operands now and then for eq/ge branches
        b.operand2   = (pick(6) == 0) ? b.operand1 : edge_operand();
        b.target_a   = (pick(2) == 0) ? b.pc : edge_operand();
        b.target_b   = rand64();
    endtask

    task automatic drive_mem_side();
        ls_ready = (pick(10) < 7);
        ls_flush = (pick(100) < 3);
    endtask

    initial begin
        seed        = 32'hf3ae_bbe5;
        id_valid    = 1'b0;
        id_bundle   = '0;
        ls_ready    = 1'b0;
        ls_flush    = 1'b0;
        report_done = 1'b0;
        n_sent      = 0;
        accepted    = 1'b0;
        @(posedge rst_n);
        while (n_sent < num_insts) begin
            @(posedge clk);
            #1;
            if (accepted) begin
                id_valid = 1'b0;
            end
            drive_mem_side();
            if (!id_valid && pick(5) != 0) begin
                make_bundle(id_bundle);
                id_valid = 1'b1;
            end
            @(negedge clk);
            accepted = id_valid && ex_ready;
            if (accepted) begin
                n_sent++;
            end
        end

        // drain the output register
        @(posedge clk);
        #1;
        id_valid = 1'b0;
        ls_ready = 1'b1;
        ls_flush = 1'b0;
        @(negedge clk);
        while (ls_valid) begin
            @(negedge clk);
        end
        #1;
        report_done = 1'b1;
        #1;
        assert_fails = i_dut.i_assert.fail_count;
        $display("summary: %0d instructions, %0d checks, %0d errors, %0d assertion failures",
                 n_sent, chk_checks, chk_errors, assert_fails);
        if (chk_errors == 0 && assert_fails == 0 && chk_checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // ********************************************************
    // timeout
    // ********************************************************
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu
    import isa_pkg::*;
(
    input  alu_op_e         op,
    input  logic            word,
    input  logic [xlen-1:0] operand1,
    input  logic [xlen-1:0] operand2,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0]         full_res;
    logic [word_w-1:0]       word_res;
    logic                    word_op;
    logic [shamt_w-1:0]      shamt;
    logic [shamt_w_word-1:0] shamt_word;

    assign shamt      = operand2[shamt_w-1:0];
    assign shamt_word = operand2[shamt_w_word-1:0];

    // ********************************************************
    // full-width operations
    // ********************************************************
    always_comb begin
        full_res = '0;
        case (op)
            alu_add:  full_res = operand1 + operand2;
            alu_sub:  full_res = operand1 - operand2;
            alu_and:  full_res = operand1 & operand2;
            alu_or:   full_res = operand1 | operand2;
            alu_xor:  full_res = operand1 ^ operand2;
            alu_sll:  full_res = operand1 << shamt;
            alu_srl:  full_res = operand1 >> shamt;
            alu_sra:  full_res = $signed(operand1) >>> shamt;
            alu_slt: begin
                full_res = {{(xlen - 1){1'b0}}, $signed(operand1) < $signed(operand2)};
            end
            alu_sltu: begin
                full_res = {{(xlen - 1){1'b0}}, operand1 < operand2};
            end
            default:  full_res = '0;
        endcase
    end

    // ********************************************************
    // word forms (addw, subw, sllw, srlw, sraw)
    // ********************************************************
    always_comb begin
        word_op  = 1'b1;
        word_res = '0;
        case (op)
            alu_add: word_res = operand1[word_w-1:0] + operand2[word_w-1:0];
            alu_sub: word_res = operand1[word_w-1:0] - operand2[word_w-1:0];
            alu_sll: word_res = operand1[word_w-1:0] << shamt_word;
            alu_srl: word_res = operand1[word_w-1:0] >> shamt_word;
            // arithmetic shift works on bit 31 as the sign
            alu_sra: word_res = $signed(operand1[word_w-1:0]) >>> shamt_word;
            default: word_op  = 1'b0;
        endcase
    end

    // word bit is ignored for logic and compare ops
    assign result = (word && word_op) ? sext_word(word_res) : full_res;

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
    import isa_pkg::*;
(
    input  logic            br_valid,
    input  logic            jump_valid,
    input  br_op_e          br_op,
    input  logic [xlen-1:0] operand1,
    input  logic [xlen-1:0] operand2,
    input  logic [xlen-1:0] target_a,
    input  logic [xlen-1:0] target_b,
    input  logic [xlen-1:0] next_pc,
    output logic            taken,
    output logic [xlen-1:0] target,
    output logic [xlen-1:0] sel_next_pc
);

    logic cond;

    // branch condition
    always_comb begin
        case (br_op)
            br_eq:   cond = (operand1 == operand2);
            br_ne:   cond = (operand1 != operand2);
            br_lt:   cond = ($signed(operand1) <  $signed(operand2));
            br_ge:   cond = ($signed(operand1) >= $signed(operand2));
            br_ltu:  cond = (operand1 <  operand2);
            br_geu:  cond = (operand1 >= operand2);
            default: cond = 1'b0;
        endcase
    end

    assign taken  = jump_valid | (br_valid & cond);

    // jalr needs bit 0 cleared, harmless for the pc-relative forms
    assign target = clear_lsb(target_a + target_b);

    assign sel_next_pc = taken ? target : next_pc;

endmodule

/* rtl/exu_ctrl.sv */
`timescale 1ns/1ps

module exu_ctrl
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            id_valid,
    input  logic            taken,
    input  logic [xlen-1:0] target,
    input  logic            slot_free,
    input  logic            ls_flush,
    output logic            ex_ready,
    output logic            ex_flush,
    output redirect_t       redirect
);

    // set once the held instruction has already redirected fetch
    logic jump_done;
    logic taken_held;
    logic accept;

    assign taken_held = id_valid & taken;

    // ********************************************************
    // acceptance
    // ********************************************************
    // a flush from memory blocks acceptance in the same cycle
    assign ex_ready = id_valid & slot_free & ~ls_flush;
    assign accept   = id_valid & ex_ready;

    // ********************************************************
    // single redirect pulse per taken instruction
    // ********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_done <= 1'b0;
        end else if (ls_flush) begin
            jump_done <= 1'b0;
        end else if (accept) begin
            jump_done <= 1'b0;
        end else if (taken_held) begin
            // stalled taken instruction, do not redirect again
            jump_done <= 1'b1;
        end
    end

    assign redirect.valid = taken_held & ~jump_done;
    assign redirect.addr  = target;

    // younger instructions in decode are wrong-path after a redirect
    assign ex_flush = ls_flush | redirect.valid;

endmodule

/* rtl/exu_out_reg.sv */
`timescale 1ns/1ps

module exu_out_reg
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         load,
    input  exec_bundle_t d,
    input  logic         ls_ready,
    input  logic         ls_flush,
    output logic         slot_free,
    output logic         ls_valid,
    output exec_bundle_t q
);

    // empty, or the current entry leaves this cycle
    assign slot_free = ~ls_valid | ls_ready;

    // ********************************************************
    // valid bit
    // ********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ls_valid <= 1'b0;
        end else if (ls_flush) begin
            ls_valid <= 1'b0;
        end else if (slot_free) begin
            ls_valid <= load;
        end
    end

    // ********************************************************
    // payload
    // ********************************************************
    // holds under back-pressure since load needs a free slot
    always_ff @(posedge clk) begin
        if (load) begin
            q <= d;
        end
    end

endmodule

/* rtl/exu_top.sv */
`timescale 1ns/1ps

module exu_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    // decode side
    input  logic           id_valid,
    input  decode_bundle_t id_bundle,
    output logic           ex_ready,
    output logic           ex_flush,
    // memory side
    output logic           ls_valid,
    output exec_bundle_t   ls_bundle,
    input  logic           ls_ready,
    input  logic           ls_flush,
    // fetch side
    output redirect_t      redirect
);

    logic [xlen-1:0] alu_result;
    logic            br_taken;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] sel_next_pc;
    logic            slot_free;
    exec_bundle_t    ex_bundle;

    // ********************************************************
    // acceptance and redirect control
    // ********************************************************
    exu_ctrl i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_valid  (id_valid),
        .taken     (br_taken),
        .target    (br_target),
        .slot_free (slot_free),
        .ls_flush  (ls_flush),
        .ex_ready  (ex_ready),
        .ex_flush  (ex_flush),
        .redirect  (redirect)
    );

    // ********************************************************
    // alu and branch unit
    // ********************************************************
    alu i_alu (
        .op       (id_bundle.alu_op),
        .word     (id_bundle.word),
        .operand1 (id_bundle.operand1),
        .operand2 (id_bundle.operand2),
        .result   (alu_result)
    );

    branch_unit i_branch (
        .br_valid    (id_bundle.br_valid),
        .jump_valid  (id_bundle.jump_valid),
        .br_op       (id_bundle.br_op),
        .operand1    (id_bundle.operand1),
        .operand2    (id_bundle.operand2),
        .target_a    (id_bundle.target_a),
        .target_b    (id_bundle.target_b),
        .next_pc     (id_bundle.next_pc),
        .taken       (br_taken),
        .target      (br_target),
        .sel_next_pc (sel_next_pc)
    );

    // bundle for the memory stage
    always_comb begin
        ex_bundle.pc         = id_bundle.pc;
        ex_bundle.next_pc    = sel_next_pc;
        ex_bundle.inst       = id_bundle.inst;
        ex_bundle.rd         = id_bundle.rd;
        ex_bundle.dest_wen   = id_bundle.dest_wen;
        ex_bundle.mem_ctrl   = id_bundle.mem_ctrl;
        ex_bundle.store_data = id_bundle.store_data;
        ex_bundle.result     = alu_result;
    end

    // ********************************************************
    // execute -> memory register
    // ********************************************************
    exu_out_reg i_out_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (ex_ready),
        .d         (ex_bundle),
        .ls_ready  (ls_ready),
        .ls_flush  (ls_flush),
        .slot_free (slot_free),
        .ls_valid  (ls_valid),
        .q         (ls_bundle)
    );

endmodule

/* rtl/isa_pkg.sv */
package isa_pkg;

    // ********************************************************
    // datapath widths
    // ********************************************************
    localparam int xlen         = 64;
    localparam int word_w       = 32;
    localparam int inst_w       = 32;
    localparam int reg_addr_w   = 5;
    localparam int shamt_w      = 6;
    localparam int shamt_w_word = 5;

    // integer alu operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    // branch conditions, funct3 order without the gaps
    typedef enum logic [2:0] {
        br_eq  = 3'd0,
        br_ne  = 3'd1,
        br_lt  = 3'd2,
        br_ge  = 3'd3,
        br_ltu = 3'd4,
        br_geu = 3'd5
    } br_op_e;

    typedef enum logic [1:0] {
        mem_byte   = 2'd0,
        mem_half   = 2'd1,
        mem_word   = 2'd2,
        mem_double = 2'd3
    } mem_size_e;

    // sign-extend a 32-bit result to xlen
    function automatic logic [xlen-1:0] sext_word(input logic [word_w-1:0] val);
        return {{(xlen - word_w){val[word_w-1]}}, val};
    endfunction

    // jump targets always land on an even address
    function automatic logic [xlen-1:0] clear_lsb(input logic [xlen-1:0] val);
        return {val[xlen-1:1], 1'b0};
    endfunction

endpackage

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    import isa_pkg::*;

    // ********************************************************
    // load/store controls carried to the memory stage
    // ********************************************************
    typedef struct packed {
        logic      load_valid;
        logic      store_valid;
        mem_size_e size;
        logic      load_signed;
    } mem_ctrl_t;

    // ********************************************************
    // decode -> execute
    // ********************************************************
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       next_pc;
        logic [inst_w-1:0]     inst;
        logic [reg_addr_w-1:0] rd;
        logic                  dest_wen;
        // alu controls
        alu_op_e               alu_op;
        logic                  word;
        // control transfer
        logic                  br_valid;
        br_op_e                br_op;
        logic                  jump_valid;
        // memory access
        mem_ctrl_t             mem_ctrl;
        logic [xlen-1:0]       store_data;
        // alu / compare operands
        logic [xlen-1:0]       operand1;
        logic [xlen-1:0]       operand2;
        // target adder inputs, pc+imm or rs1+imm
        logic [xlen-1:0]       target_a;
        logic [xlen-1:0]       target_b;
    } decode_bundle_t;

    // ********************************************************
    // execute -> memory
    // ********************************************************
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       next_pc;
        logic [inst_w-1:0]     inst;
        logic [reg_addr_w-1:0] rd;
        logic                  dest_wen;
        mem_ctrl_t             mem_ctrl;
        logic [xlen-1:0]       store_data;
        // alu result, doubles as the address for loads and stores
        logic [xlen-1:0]       result;
    } exec_bundle_t;

    // redirect toward fetch
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
    } redirect_t;

endpackage

/* tb.f */
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/exu_ctrl.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/exu_out_reg.sv
rtl/exu_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/exu_assert.sv
dv/tb_top.sv
